// ==== design/mapper_defs.svh ====
/* Memory mapper constants
   Region count and the layout of the mapper register file */
`ifndef MAPPER_DEFS_SVH
`define MAPPER_DEFS_SVH

// Decoded address regions
`define MAPPER_REGIONS 8

// Byte registers in the mapper
`define MMR_COUNT 32

// Region n base register sits at 16+2n
`define MMR_BASE_OFS 16

// Region n size register sits at 17+2n, low 2 bits only
`define MMR_SIZE_OFS 17

`endif

// ==== design/cpu_bus_pkg.sv ====
/* 68000 bus types
   CPU bus cycle signals and the bus arbitration outputs */
`include "mapper_defs.svh"

package cpu_bus_pkg;

    // One 68000 bus cycle as seen by the mapper
    typedef struct packed {
        logic [23:1] addr;  // Word address
        logic [15:0] dout;  // CPU write data
        logic [1:0]  dswn;  // Data strobes, active low
        logic [2:0]  fc;    // Function code
        logic        asn;   // Address strobe, active low
    } cpu_req_t;

    // Arbitration lines driven towards the CPU
    typedef struct packed {
        logic brn;          // Bus request, active low
        logic bgackn;       // Bus grant acknowledge, active low
    } cpu_arb_t;

endpackage

// ==== design/mapper_pkg.sv ====
/* Mapper types
   Register write requests, region configuration and region select */
`include "mapper_defs.svh"

package mapper_pkg;

    // Single byte write into the register file
    typedef struct packed {
        logic       en;
        logic [4:0] idx;    // Register index
        logic [7:0] data;
    } mmr_wr_t;

    // Per region decode setup
    typedef struct packed {
        logic [7:0] base;   // Compared with addr[23:16]
        logic [1:0] size;   // 0 64k, 1 128k, 2 512k, 3 2M
    } region_cfg_t;

    // One-hot region select, zero when nothing matches
    typedef logic [`MAPPER_REGIONS-1:0] region_sel_t;

endpackage

// ==== design/mapper_regs.sv ====
/* Mapper register file
   32 byte registers written by CPU and MCU, unpacked into region setup */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module mapper_regs
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  mmr_wr_t     cpu_wr,
    input  mmr_wr_t     mcu_wr,
    input  region_sel_t active,                     // From decoder
    input  logic [4:0]  rd_idx,                     // CPU readback index
    input  logic [4:0]  mcu_idx,                    // MCU readback index
    output region_cfg_t cfg [`MAPPER_REGIONS],
    output logic [7:0]  cpu_rd,
    output logic [7:0]  mcu_rd
);

    logic [7:0] mmr [`MMR_COUNT];
    logic       cpu_wr_ok;

    // CPU reaches the registers only outside all regions
    assign cpu_wr_ok = cpu_wr.en && (active == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MMR_COUNT; i++) begin
                mmr[i] <= 8'h00;
            end
        end else begin
            if (cpu_wr_ok) begin
                mmr[cpu_wr.idx] <= cpu_wr.data;
            end
            // Later assignment, so MCU wins a collision
            if (mcu_wr.en) begin
                mmr[mcu_wr.idx] <= mcu_wr.data;
            end
        end
    end

    // Fixed layout, base then size per region
    for (genvar n = 0; n < `MAPPER_REGIONS; n++) begin : g_cfg
        assign cfg[n].base = mmr[`MMR_BASE_OFS + 2 * n];
        assign cfg[n].size = mmr[`MMR_SIZE_OFS + 2 * n][1:0];   // Upper bits ignored
    end

    assign cpu_rd = mmr[rd_idx];    // Combinational read ports
    assign mcu_rd = mmr[mcu_idx];

endmodule

// ==== design/region_decode.sv ====
/* Region decoder
   Matches the CPU address against each region, keeps the lowest hit, forms the offset */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module region_decode
    import mapper_pkg::*;
(
    input  logic [23:1] addr,
    input  region_cfg_t cfg [`MAPPER_REGIONS],
    output region_sel_t active,
    output logic [23:1] addr_out
);

    region_sel_t match;         // Raw hits, possibly several
    logic [1:0]  sel_size;      // Size code of the winner
    logic [23:1] keep_mask;

    always_comb begin
        match = '0;
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            // Larger regions compare fewer upper bits
            case (cfg[n].size)
                2'd0: match[n] = addr[23:16] == cfg[n].base;         // 64 kB
                2'd1: match[n] = addr[23:17] == cfg[n].base[7:1];    // 128 kB
                2'd2: match[n] = addr[23:19] == cfg[n].base[7:3];    // 512 kB
                default: match[n] = addr[23:21] == cfg[n].base[7:5]; // 2 MB
            endcase
        end
    end

    // Isolate lowest set bit, lowest region wins
    assign active = match & (~match + 1'b1);

    always_comb begin
        sel_size = 2'd0;
        for (int n = 0; n < `MAPPER_REGIONS; n++) begin
            if (active[n]) begin
                sel_size = cfg[n].size;     // One-hot, at most one hit
            end
        end
    end

    // Clear the compared bits, keep the in-region offset
    always_comb begin
        case (sel_size)
            2'd0:    keep_mask = {8'h00, {15{1'b1}}};
            2'd1:    keep_mask = {7'h00, {16{1'b1}}};
            2'd2:    keep_mask = {5'h00, {18{1'b1}}};
            default: keep_mask = {3'h0, {20{1'b1}}};
        endcase
    end

    assign addr_out = (active != '0) ? (addr & keep_mask) : addr;  // Pass through if unmapped

endmodule

// ==== design/vblank_irq.sv ====
/* VBLANK interrupt
   Level-1 request set on the vint rising edge, cleared by interrupt acknowledge */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module vblank_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic [2:0] fc,
    input  logic       asn,
    output logic       irqn
);

    logic vint_l;   // Previous vint sample
    logic inta;     // CPU interrupt acknowledge cycle

    assign inta = (&fc) & ~asn;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vint_l <= 1'b0;
            irqn   <= 1'b1;
        end else begin
            vint_l <= vint;
            if (inta) begin
                irqn <= 1'b1;               // Ack beats a new edge
            end else if (vint && !vint_l) begin
                irqn <= 1'b0;
            end
        end
    end

endmodule

// ==== design/bus_arbiter.sv ====
/* 68000 bus arbiter
   BR/BG/BGACK takeover and release on behalf of the microcontroller */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module bus_arbiter
    import cpu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,       // CPU clock enable
    input  logic     req,       // MCU wants the bus
    input  logic     bgn,
    input  logic     asn,
    input  logic     dtackn,
    output cpu_arb_t ctl,
    output logic     grant
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // BR low, waiting for grant
        ST_OWN      // BGACK low, MCU owns the bus
    } arb_state_t;

    arb_state_t state;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            ctl.brn    <= 1'b1;
            ctl.bgackn <= 1'b1;
        end else if (cen) begin
            case (state)
                ST_IDLE: if (req) begin
                    ctl.brn <= 1'b0;
                    state   <= ST_REQ;
                end
                ST_REQ: if (!req) begin
                    ctl.brn <= 1'b1;        // Request withdrawn
                    state   <= ST_IDLE;
                end else if (!bgn && asn && dtackn) begin
                    // Granted and previous cycle finished
                    ctl.bgackn <= 1'b0;
                    ctl.brn    <= 1'b1;
                    state      <= ST_OWN;
                end
                ST_OWN: if (!req) begin
                    ctl.bgackn <= 1'b1;     // Hand bus back
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign grant = ~ctl.bgackn;

endmodule

// ==== design/mem_mapper.sv ====
/* Memory mapper top
   Register file, region decoder, VBLANK interrupt and bus arbiter */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module mem_mapper
    import cpu_bus_pkg::*;
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cen,
    input  logic        vint,
    input  cpu_req_t    cpu,
    input  logic        cpu_bgn,
    input  logic        cpu_dtackn,
    input  logic        mcu_wr,
    input  logic [15:0] mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_bus_req,
    output logic [7:0]  mcu_din,
    output logic        mcu_bus_grant,
    output logic        cpu_irqn,
    output cpu_arb_t    bus_ctl,
    output region_sel_t active,
    output logic [23:1] addr_out,
    output logic [15:0] bus_din
);

    mmr_wr_t     wr_cpu;
    mmr_wr_t     wr_mcu;
    region_cfg_t cfg [`MAPPER_REGIONS];
    logic [7:0]  cpu_rd;

    // CPU low byte write, gated by region select inside the register file
    assign wr_cpu = '{en: ~cpu.asn & ~cpu.dswn[0], idx: cpu.addr[5:1], data: cpu.dout[7:0]};
    assign wr_mcu = '{en: mcu_wr, idx: mcu_addr[4:0], data: mcu_dout};

    // Register readback only when nothing is mapped
    assign bus_din = (active == '0) ? {8'h00, cpu_rd} : 16'h0000;

    mapper_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .cpu_wr  (wr_cpu),
        .mcu_wr  (wr_mcu),
        .active  (active),
        .rd_idx  (cpu.addr[5:1]),
        .mcu_idx (mcu_addr[4:0]),
        .cfg     (cfg),
        .cpu_rd  (cpu_rd),
        .mcu_rd  (mcu_din)
    );

    region_decode u_decode (
        .addr     (cpu.addr),
        .cfg      (cfg),
        .active   (active),
        .addr_out (addr_out)
    );

    vblank_irq u_irq (
        .clk  (clk),
        .rst  (rst),
        .vint (vint),
        .fc   (cpu.fc),
        .asn  (cpu.asn),
        .irqn (cpu_irqn)
    );

    bus_arbiter u_arb (
        .clk    (clk),
        .rst    (rst),
        .cen    (cpu_cen),
        .req    (mcu_bus_req),
        .bgn    (cpu_bgn),
        .asn    (cpu.asn),
        .dtackn (cpu_dtackn),
        .ctl    (bus_ctl),
        .grant  (mcu_bus_grant)
    );

endmodule

// ==== testbench/mem_mapper_tb.sv ====
/* Memory mapper testbench
   Random decode checks against a register mirror, interrupt and bus takeover */
`timescale 1ns/1ps
`include "mapper_defs.svh"

module mem_mapper_tb
    import cpu_bus_pkg::*;
    import mapper_pkg::*;
();

    localparam int SIG_IRQN   = 0;
    localparam int SIG_BRN    = 1;
    localparam int SIG_BGACKN = 2;

    typedef struct packed {
        region_sel_t sel;
        logic [23:1] off;
    } decode_t;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    logic        vint;
    cpu_req_t    cpu;
    logic        cpu_bgn;
    logic        cpu_dtackn;
    logic        mcu_wr;
    logic [15:0] mcu_addr;
    logic [7:0]  mcu_dout;
    logic        mcu_bus_req;
    logic [7:0]  mcu_din;
    logic        mcu_bus_grant;
    logic        cpu_irqn;
    cpu_arb_t    bus_ctl;
    region_sel_t active;
    logic [23:1] addr_out;
    logic [15:0] bus_din;

    logic [7:0]  mirror [`MMR_COUNT];      // Expected register contents
    logic [31:0] rand_state = 32'h8696edba;
    decode_t     wr_dec;
    decode_t     chk_dec;
    logic [15:0] exp_din;                  // Expected register readback
    logic        chk_en;
    string       test_name;
    int          errors;
    int          checks;
    int          tests;

    mem_mapper u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Expected decode from the mirror, lowest region first
    function automatic decode_t expect_decode(logic [23:1] a);
        decode_t    d;
        int         nbits;
        logic [7:0] base;
        d.sel = '0;
        d.off = a;                         // Unmapped passes through
        for (int n = `MAPPER_REGIONS - 1; n >= 0; n--) begin  // Descending, lowest hit kept
            base = mirror[`MMR_BASE_OFS + 2 * n];
            case (mirror[`MMR_SIZE_OFS + 2 * n][1:0])
                2'd0: nbits = 8;
                2'd1: nbits = 7;
                2'd2: nbits = 5;
                default: nbits = 3;
            endcase
            if ((a[23:16] >> (8 - nbits)) == (base >> (8 - nbits))) begin
                d.sel = region_sel_t'(1) << n;
                d.off = a & ((23'd1 << (23 - nbits)) - 23'd1);
            end
        end
        return d;
    endfunction

    // Mirror follows the register file write rules
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MMR_COUNT; i++) begin
                mirror[i] = 8'h00;
            end
        end else begin
            wr_dec = expect_decode(cpu.addr);
            if (!cpu.asn && !cpu.dswn[0] && wr_dec.sel == '0) begin
                mirror[cpu.addr[5:1]] = cpu.dout[7:0];
            end
            if (mcu_wr) begin
                mirror[mcu_addr[4:0]] = mcu_dout;  // MCU last, wins collision
            end
        end
    end

    task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    // Decode compare, mid cycle
    always @(negedge clk) begin
        if (chk_en) begin
            chk_dec = expect_decode(cpu.addr);
            // Readback only while unmapped, zero otherwise
            exp_din = (chk_dec.sel == '0) ? {8'h00, mirror[cpu.addr[5:1]]} : 16'h0000;
            checks++;
            if (active !== chk_dec.sel) report_mismatch("active", chk_dec.sel, active);
            if (addr_out !== chk_dec.off) report_mismatch("addr_out", chk_dec.off, addr_out);
            if (bus_din !== exp_din) report_mismatch("bus_din", exp_din, bus_din);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic cpu_access(logic [23:1] a, logic [7:0] data, logic wr);
        next_cycle();
        cpu.addr = a;
        cpu.dout = {8'h00, data};
        cpu.dswn = wr ? 2'b10 : 2'b11;     // Low byte strobe only
        cpu.asn  = ~wr;
        cpu.fc   = 3'b101;
        mcu_wr   = 1'b0;
    endtask

    task automatic mcu_write(logic [4:0] idx, logic [7:0] data);
        next_cycle();
        cpu.asn  = 1'b1;                   // CPU idle
        mcu_wr   = 1'b1;
        mcu_addr = {11'h000, idx};
        mcu_dout = data;
    endtask

    function automatic logic probe(int which);
        case (which)
            SIG_IRQN: return cpu_irqn;
            SIG_BRN:  return bus_ctl.brn;
            default:  return bus_ctl.bgackn;
        endcase
    endfunction

    // Poll on falling edges up to limit cycles
    task automatic wait_for(int which, logic lvl, int limit, string what);
        int n;
        n = 0;
        @(negedge clk);
        while (probe(which) !== lvl && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (probe(which) !== lvl) begin
            $display("TIMEOUT %s: %s not seen within %0d cycles", test_name, what, limit);
            errors++;
        end
    endtask

    task automatic finish_test(int start_errs);
        tests++;
        $display("test %-12s %s, %0d errors", test_name,
                 (errors == start_errs) ? "ok" : "bad", errors - start_errs);
    endtask

    initial begin
        int          start_errs;
        logic [23:1] a;
        logic [7:0]  d;
        logic [7:0]  saved;
        logic [4:0]  k;
        rst         = 1'b1;
        cpu_cen     = 1'b1;
        vint        = 1'b0;
        cpu         = '{addr: '0, dout: '0, dswn: 2'b11, fc: 3'b101, asn: 1'b1};
        cpu_bgn     = 1'b1;
        cpu_dtackn  = 1'b1;
        mcu_wr      = 1'b0;
        mcu_addr    = '0;
        mcu_dout    = '0;
        mcu_bus_req = 1'b0;
        chk_en      = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        repeat (16) @(posedge clk);
        #5 rst = 1'b0;

        test_name  = "reset_state";
        start_errs = errors;
        @(negedge clk);
        if (cpu_irqn !== 1'b1) report_mismatch("cpu_irqn", 1, cpu_irqn);
        if (bus_ctl.brn !== 1'b1) report_mismatch("brn", 1, bus_ctl.brn);
        if (bus_ctl.bgackn !== 1'b1) report_mismatch("bgackn", 1, bus_ctl.bgackn);
        if (mcu_bus_grant !== 1'b0) report_mismatch("grant", 0, mcu_bus_grant);
        chk_en = 1'b1;
        for (int i = 0; i < 50; i++) begin
            a = 23'(next_rand());
            if (i % 2) a[23:16] = 8'h00;   // Half inside region 0
            cpu_access(a, 8'h00, 1'b0);
            @(negedge clk);
            if (active !== ((a[23:16] == 8'h00) ? 8'h01 : 8'h00)) begin
                report_mismatch("region 0", (a[23:16] == 8'h00) ? 8'h01 : 8'h00, active);
            end
        end
        finish_test(start_errs);

        test_name  = "cpu_program";
        start_errs = errors;
        for (int n = 0; n < 16; n++) begin
            d = 8'(next_rand());
            k = 5'(`MMR_BASE_OFS + n);
            cpu_access({8'hFF, 10'h000, k}, d & 8'h7F, 1'b1);   // Bases below 0x80
        end
        for (int i = 0; i < 200; i++) begin
            a = 23'(next_rand());
            if (i % 4 != 0) a[23] = 1'b0;  // Mostly in the programmed half
            cpu_access(a, 8'h00, 1'b0);
        end
        saved = mirror[`MMR_BASE_OFS];
        cpu_access({saved, 10'h000, 5'(`MMR_BASE_OFS)}, ~saved, 1'b1);  // Inside region 0
        cpu_access({8'hFF, 10'h000, 5'(`MMR_BASE_OFS)}, 8'h00, 1'b0);
        @(negedge clk);
        if (bus_din !== {8'h00, saved}) report_mismatch("blocked write", saved, bus_din);
        finish_test(start_errs);

        test_name  = "mcu_port";
        start_errs = errors;
        for (int i = 0; i < 32; i++) begin
            k = 5'(next_rand());
            d = 8'(next_rand());
            if (k >= `MMR_BASE_OFS) d[7] = 1'b0;   // Keep 0xFF unmapped
            mcu_write(k, d);
        end
        for (int i = 0; i < `MMR_COUNT; i++) begin
            k = 5'(i);
            cpu_access({8'hFF, 10'h000, k}, 8'h00, 1'b0);
            mcu_addr = {11'h000, k};
            @(negedge clk);
            if (mcu_din !== mirror[i]) report_mismatch("mcu_din", mirror[i], mcu_din);
            if (bus_din !== {8'h00, mirror[i]}) report_mismatch("bus_din", mirror[i], bus_din);
        end
        k = 5'd20;                         // Region 2 base
        mcu_write(k, 8'h22);
        cpu.addr = {8'hFF, 10'h000, k};    // Same cycle CPU write
        cpu.dout = 16'h0011;
        cpu.dswn = 2'b10;
        cpu.asn  = 1'b0;
        cpu_access({8'hFF, 10'h000, k}, 8'h00, 1'b0);
        @(negedge clk);
        if (mcu_din !== 8'h22) report_mismatch("collision", 8'h22, mcu_din);
        finish_test(start_errs);

        test_name  = "overlap";
        start_errs = errors;
        mcu_write(5'd16, 8'h7F);           // Region 0 out of the way
        mcu_write(5'd17, 8'h00);
        mcu_write(5'd18, 8'h44);           // Region 1, 64 kB at 0x44
        mcu_write(5'd19, 8'h00);
        mcu_write(5'd20, 8'h40);           // Region 2, 2 MB over 0x40..0x5F
        mcu_write(5'd21, 8'h03);
        cpu_access({8'h44, 15'h1234}, 8'h00, 1'b0);
        @(negedge clk);
        if (active !== 8'h02) report_mismatch("both hit", 8'h02, active);
        if (addr_out !== {8'h00, 15'h1234}) report_mismatch("offset 1", 23'h1234, addr_out);
        cpu_access({8'h50, 15'h0abc}, 8'h00, 1'b0);
        @(negedge clk);
        if (active !== 8'h04) report_mismatch("region 2", 8'h04, active);
        if (addr_out !== {3'b000, 5'h10, 15'h0abc}) begin
            report_mismatch("offset 2", {3'b000, 5'h10, 15'h0abc}, addr_out);
        end
        finish_test(start_errs);

        test_name  = "vblank_irq";
        start_errs = errors;
        next_cycle();
        vint = 1'b1;
        wait_for(SIG_IRQN, 1'b0, 2, "cpu_irqn low");
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (cpu_irqn !== 1'b0) report_mismatch("irqn held", 0, cpu_irqn);
        end
        next_cycle();
        vint = 1'b0;
        next_cycle();
        // Still pending with vint low, only the ack clears it
        if (cpu_irqn !== 1'b0) report_mismatch("irqn before ack", 0, cpu_irqn);
        cpu.fc   = 3'b111;                 // Interrupt acknowledge
        cpu.dswn = 2'b11;
        cpu.asn  = 1'b0;
        wait_for(SIG_IRQN, 1'b1, 2, "cpu_irqn high");
        next_cycle();
        cpu.fc  = 3'b101;
        cpu.asn = 1'b1;
        finish_test(start_errs);

        test_name  = "bus_takeover";
        start_errs = errors;
        next_cycle();
        mcu_bus_req = 1'b1;
        wait_for(SIG_BRN, 1'b0, 3, "brn low");
        for (int i = 0; i < 3; i++) begin  // No grant from the CPU yet
            @(negedge clk);
            if (bus_ctl.bgackn !== 1'b1) report_mismatch("bgackn early", 1, bus_ctl.bgackn);
        end
        next_cycle();
        cpu_bgn    = 1'b0;
        cpu.asn    = 1'b1;
        cpu_dtackn = 1'b1;
        wait_for(SIG_BGACKN, 1'b0, 3, "bgackn low");
        if (bus_ctl.brn !== 1'b1) report_mismatch("brn released", 1, bus_ctl.brn);
        if (mcu_bus_grant !== 1'b1) report_mismatch("grant", 1, mcu_bus_grant);
        next_cycle();
        mcu_bus_req = 1'b0;
        wait_for(SIG_BGACKN, 1'b1, 3, "bgackn high");
        if (mcu_bus_grant !== 1'b0) report_mismatch("grant dropped", 0, mcu_bus_grant);
        next_cycle();
        cpu_bgn = 1'b1;
        finish_test(start_errs);

        chk_en = 1'b0;
        $display("tests %0d, decode checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
design/cpu_bus_pkg.sv
design/mapper_pkg.sv
design/mapper_regs.sv
design/region_decode.sv
design/vblank_irq.sv
design/bus_arbiter.sv
design/mem_mapper.sv
testbench/mem_mapper_tb.sv
